// ==== hw/cpu_pkg.sv ====
// ----------------------------------------------------------
// width constants, opcode enum and ALU operation enum
// for the 8-bit single-cycle core
// ----------------------------------------------------------
package cpu_pkg;

    // datapath widths
    localparam int data_w     = 8;
    localparam int instr_w    = 32;
    localparam int reg_addr_w = 3;

    // instruction fields
    //   [31:24] opcode
    //   [23:16] signed word offset (j, beq, bne)
    //   [18:16] destination register
    //   [10:8]  source register 1
    //   [7:0]   immediate, or source register 2 in [2:0]

    // opcode encodings as seen in instruction[31:24]
    typedef enum logic [7:0] {
        op_loadi = 8'd0,
        op_mov   = 8'd1,
        op_add   = 8'd2,
        op_sub   = 8'd3,
        op_and   = 8'd4,
        op_or    = 8'd5,
        op_j     = 8'd6,
        op_beq   = 8'd7,
        op_bne   = 8'd8,
        // memory access, address from register
        op_lwd   = 8'd9,
        // memory access, address from immediate
        op_lwi   = 8'd10,
        op_swd   = 8'd11,
        op_swi   = 8'd12
    } opcode_e;

    // ALU select
    typedef enum logic [2:0] {
        // pass operand 2 straight through
        alu_fwd = 3'd0,
        alu_add = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3
    } alu_op_e;

endpackage

// ==== hw/pc_unit.sv ====
// ----------------------------------------------------------
// program counter register with pc+4 and branch target
// adders and the next-pc select
// ----------------------------------------------------------
`timescale 1ns/10ps

module pc_unit (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        hold,
    input  logic        take_target,
    input  logic [7:0]  offset,
    output logic [31:0] pc
);

    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic [31:0] offset_bytes;

    // sequential fall-through
    assign pc_plus4 = pc + 32'd4;

    // sign-extended word offset scaled to bytes
    assign offset_bytes = {{22{offset[7]}}, offset, 2'b00};
    // target is relative to the next instruction
    assign pc_target = pc_plus4 + offset_bytes;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (!hold) begin
            // frozen while a memory access is pending
            pc <= take_target ? pc_target : pc_plus4;
        end
    end

endmodule

// ==== hw/control_unit.sv ====
// ----------------------------------------------------------
// opcode decode into datapath controls, memory strobes,
// branch resolution and the stall hold
// ----------------------------------------------------------
`timescale 1ns/10ps

module control_unit (
    input  logic              [7:0] opcode,
    input  logic                    busywait,
    input  logic                    zero,
    output logic                    reg_write,
    output logic                    imm_sel,
    output logic                    negate_sel,
    output cpu_pkg::alu_op_e        alu_op,
    output logic                    wb_mem_sel,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    take_target,
    output logic                    hold
);

    cpu_pkg::opcode_e op;
    logic             reg_write_raw;
    logic             jump;
    logic             branch_eq;
    logic             branch_ne;

    assign op = cpu_pkg::opcode_e'(opcode);

    always_comb begin
        // unknown opcodes keep every control low
        reg_write_raw = 1'b0;
        imm_sel       = 1'b0;
        negate_sel    = 1'b0;
        alu_op        = cpu_pkg::alu_fwd;
        wb_mem_sel    = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        jump          = 1'b0;
        branch_eq     = 1'b0;
        branch_ne     = 1'b0;
        case (op)
            cpu_pkg::op_loadi: begin
                reg_write_raw = 1'b1;
                imm_sel       = 1'b1;
            end
            cpu_pkg::op_mov: begin
                reg_write_raw = 1'b1;
            end
            cpu_pkg::op_add: begin
                reg_write_raw = 1'b1;
                alu_op        = cpu_pkg::alu_add;
            end
            cpu_pkg::op_sub: begin
                // rs1 + (-rs2)
                reg_write_raw = 1'b1;
                negate_sel    = 1'b1;
                alu_op        = cpu_pkg::alu_add;
            end
            cpu_pkg::op_and: begin
                reg_write_raw = 1'b1;
                alu_op        = cpu_pkg::alu_and;
            end
            cpu_pkg::op_or: begin
                reg_write_raw = 1'b1;
                alu_op        = cpu_pkg::alu_or;
            end
            cpu_pkg::op_j: begin
                jump = 1'b1;
            end
            cpu_pkg::op_beq: begin
                // compare by subtracting rs2 from rs1
                negate_sel = 1'b1;
                alu_op     = cpu_pkg::alu_add;
                branch_eq  = 1'b1;
            end
            cpu_pkg::op_bne: begin
                negate_sel = 1'b1;
                alu_op     = cpu_pkg::alu_add;
                branch_ne  = 1'b1;
            end
            cpu_pkg::op_lwd: begin
                reg_write_raw = 1'b1;
                wb_mem_sel    = 1'b1;
                mem_read      = 1'b1;
            end
            cpu_pkg::op_lwi: begin
                reg_write_raw = 1'b1;
                imm_sel       = 1'b1;
                wb_mem_sel    = 1'b1;
                mem_read      = 1'b1;
            end
            cpu_pkg::op_swd: begin
                mem_write = 1'b1;
            end
            cpu_pkg::op_swi: begin
                imm_sel   = 1'b1;
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // j always taken and beq/bne follow the zero flag
    assign take_target = jump | (branch_eq & zero) | (branch_ne & ~zero);

    // stall only while our own request is outstanding
    assign hold = busywait & (mem_read | mem_write);

    // no writeback until the load data is in
    assign reg_write = reg_write_raw & ~hold;

endmodule

// ==== hw/reg_file.sv ====
// ----------------------------------------------------------
// eight 8-bit registers, two async read ports,
// one synchronous write port
// ----------------------------------------------------------
`timescale 1ns/10ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           write_en,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_addr,
    input  logic [cpu_pkg::data_w-1:0]     write_data,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_addr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_addr2,
    output logic [cpu_pkg::data_w-1:0]     read_data1,
    output logic [cpu_pkg::data_w-1:0]     read_data2
);

    localparam int num_regs = 1 << cpu_pkg::reg_addr_w;

    logic [cpu_pkg::data_w-1:0] regs [num_regs];

    // write at the clock edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // every register starts at zero
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // reads are combinational
    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

endmodule

// ==== hw/alu.sv ====
// ----------------------------------------------------------
// 8-bit ALU with forward, add, and, or and a zero flag
// ----------------------------------------------------------
`timescale 1ns/10ps

module alu (
    input  logic [cpu_pkg::data_w-1:0] operand1,
    input  logic [cpu_pkg::data_w-1:0] operand2,
    input  cpu_pkg::alu_op_e           op,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic                       zero
);

    always_comb begin
        case (op)
            // loadi, mov and address pass-through
            cpu_pkg::alu_fwd: begin
                result = operand2;
            end
            // also sub and compare, operand2 arrives negated
            cpu_pkg::alu_add: begin
                result = operand1 + operand2;
            end
            cpu_pkg::alu_and: begin
                result = operand1 & operand2;
            end
            cpu_pkg::alu_or: begin
                result = operand1 | operand2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // equal operands give zero after the subtract
    assign zero = (result == '0);

endmodule

// ==== hw/cpu_core.sv ====
// ----------------------------------------------------------
// single-cycle datapath: pc unit, decode, register file,
// ALU, operand and writeback muxes
// ----------------------------------------------------------
`timescale 1ns/10ps

module cpu_core (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [cpu_pkg::instr_w-1:0] instruction,
    input  logic [cpu_pkg::data_w-1:0]  mem_readdata,
    input  logic                        busywait,
    output logic [31:0]                 pc,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [cpu_pkg::data_w-1:0]  mem_address,
    output logic [cpu_pkg::data_w-1:0]  mem_writedata
);

    // instruction fields
    logic [7:0]                       opcode;
    logic [7:0]                       offset;
    logic [cpu_pkg::reg_addr_w-1:0]   dest_addr;
    logic [cpu_pkg::reg_addr_w-1:0]   src1_addr;
    logic [cpu_pkg::reg_addr_w-1:0]   src2_addr;
    logic [cpu_pkg::data_w-1:0]       immediate;

    // control
    logic                             reg_write;
    logic                             imm_sel;
    logic                             negate_sel;
    cpu_pkg::alu_op_e                 alu_op;
    logic                             wb_mem_sel;
    logic                             take_target;
    logic                             hold;

    // datapath
    logic [cpu_pkg::data_w-1:0]       read_data1;
    logic [cpu_pkg::data_w-1:0]       read_data2;
    logic [cpu_pkg::data_w-1:0]       read_data2_neg;
    logic [cpu_pkg::data_w-1:0]       operand2;
    logic [cpu_pkg::data_w-1:0]       alu_result;
    logic                             zero;
    logic [cpu_pkg::data_w-1:0]       writeback;

    assign opcode    = instruction[31:24];
    assign offset    = instruction[23:16];
    assign dest_addr = instruction[18:16];
    assign src1_addr = instruction[10:8];
    assign src2_addr = instruction[2:0];
    assign immediate = instruction[7:0];

    pc_unit u_pc (
        .clk         (clk),
        .arst_n      (arst_n),
        .hold        (hold),
        .take_target (take_target),
        .offset      (offset),
        .pc          (pc)
    );

    control_unit u_ctrl (
        .opcode      (opcode),
        .busywait    (busywait),
        .zero        (zero),
        .reg_write   (reg_write),
        .imm_sel     (imm_sel),
        .negate_sel  (negate_sel),
        .alu_op      (alu_op),
        .wb_mem_sel  (wb_mem_sel),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .take_target (take_target),
        .hold        (hold)
    );

    reg_file u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .write_en   (reg_write),
        .write_addr (dest_addr),
        .write_data (writeback),
        .read_addr1 (src1_addr),
        .read_addr2 (src2_addr),
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    // two's complement for sub, beq, bne
    assign read_data2_neg = ~read_data2 + 1'b1;

    // immediate wins over the register path
    assign operand2 = imm_sel    ? immediate      :
                      negate_sel ? read_data2_neg : read_data2;

    alu u_alu (
        .operand1 (read_data1),
        .operand2 (operand2),
        .op       (alu_op),
        .result   (alu_result),
        .zero     (zero)
    );

    // loads write back memory data
    assign writeback = wb_mem_sel ? mem_readdata : alu_result;

    // address is the forwarded register or immediate
    assign mem_address   = alu_result;
    assign mem_writedata = read_data1;

    // request must not move while the memory is busy
    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_read || mem_write) && busywait |=>
            (mem_read || mem_write) && $stable(mem_address) && $stable(mem_writedata))
        else $error("memory request changed during busywait");

endmodule

// ==== hw/data_memory.sv ====
// ----------------------------------------------------------
// 256-byte data memory with a fixed-latency busywait
// ----------------------------------------------------------
`timescale 1ns/10ps

module data_memory #(
    parameter int mem_latency = 3
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       read,
    input  logic                       write,
    input  logic [7:0]                 address,
    input  logic [cpu_pkg::data_w-1:0] writedata,
    output logic [cpu_pkg::data_w-1:0] readdata,
    output logic                       busywait
);

    localparam int depth = 256;
    localparam int cnt_w = $clog2(mem_latency + 1);

    logic [cpu_pkg::data_w-1:0] mem [depth];
    // cycles already spent on the current request
    logic [cnt_w-1:0]           wait_cnt;
    logic                       request;

    assign request = read | write;

    // busy from the first cycle of a request, low in the last
    assign busywait = request && (wait_cnt < mem_latency);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (request && busywait) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            // access done or no request, ready for the next one
            wait_cnt <= '0;
        end
    end

    // store lands at the edge that ends the completing cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (write && !busywait) begin
            mem[address] <= writedata;
        end
    end

    // read data only shown in the completing cycle
    assign readdata = (read && !busywait) ? mem[address] : '0;

    // the stall is bounded by the latency
    busy_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        busywait [*mem_latency] |=> !busywait)
        else $error("busywait longer than %0d cycles", mem_latency);

endmodule

// ==== hw/cpu_system.sv ====
// ----------------------------------------------------------
// top level: core plus data memory, instruction port
// and store bus brought out
// ----------------------------------------------------------
`timescale 1ns/10ps

module cpu_system #(
    parameter int mem_latency = 3
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [cpu_pkg::instr_w-1:0] instruction,
    output logic [31:0]                 pc,
    output logic                        mem_write,
    output logic [cpu_pkg::data_w-1:0]  mem_address,
    output logic [cpu_pkg::data_w-1:0]  mem_writedata
);

    // internal side of the memory handshake
    logic                       mem_read;
    logic [cpu_pkg::data_w-1:0] mem_readdata;
    logic                       busywait;

    cpu_core u_core (
        .clk           (clk),
        .arst_n        (arst_n),
        .instruction   (instruction),
        .mem_readdata  (mem_readdata),
        .busywait      (busywait),
        .pc            (pc),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_writedata (mem_writedata)
    );

    data_memory #(
        .mem_latency (mem_latency)
    ) u_dmem (
        .clk       (clk),
        .arst_n    (arst_n),
        .read      (mem_read),
        .write     (mem_write),
        .address   (mem_address),
        .writedata (mem_writedata),
        .readdata  (mem_readdata),
        .busywait  (busywait)
    );

endmodule

// ==== verif/tb_cpu_system.sv ====
// ----------------------------------------------------------
// testbench: clock, reset, random program, instruction
// memory model, ISA reference model and checks
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_cpu_system;

    localparam int mem_latency = 3;
    localparam int n_regs      = 8;
    localparam int n_random    = 60;
    localparam int prog_len    = n_regs + n_random + 1;
    localparam int final_idx   = prog_len - 1;
    // four times the worst case of every instruction stalling
    localparam int cycle_limit = 4 * prog_len * (mem_latency + 1);

    logic        clk;
    logic        arst_n;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        mem_write;
    logic [7:0]  mem_address;
    logic [7:0]  mem_writedata;

    // instruction memory and generator state
    logic [31:0] program_mem [prog_len];
    logic [15:0] lfsr_state;

    // reference model state
    logic [7:0]  model_regs [8];
    logic [7:0]  model_dmem [256];
    logic [31:0] exp_pc;
    int          cycles_here;
    int          cycle_cnt;
    logic        done;

    cpu_system #(
        .mem_latency (mem_latency)
    ) u_cpu_system (
        .clk           (clk),
        .arst_n        (arst_n),
        .instruction   (instruction),
        .pc            (pc),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_writedata (mem_writedata)
    );

    always #20 clk = ~clk;

    // combinational fetch, zero outside the program or before reset
    assign instruction = ($isunknown(pc) || pc[31:2] >= prog_len) ? 32'h0 :
                         program_mem[pc[31:2]];

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] encode(input cpu_pkg::opcode_e op, input logic [7:0] hi,
                                           input logic [2:0] rs1, input logic [7:0] lo);
        return {op, hi, 5'b00000, rs1, lo};
    endfunction

    task automatic build_program();
        logic [7:0]       r;
        logic [7:0]       hi;
        logic [7:0]       lo;
        logic [2:0]       rs1;
        logic [2:0]       last_dest;
        int               max_skip;
        cpu_pkg::opcode_e op;
        lfsr_state = 16'd76;
        last_dest  = 3'd0;
        // prologue, every register gets a value
        for (int i = 0; i < n_regs; i++) begin
            take_bits(8, lo);
            program_mem[i] = encode(cpu_pkg::op_loadi, 8'(i), 3'd0, lo);
            last_dest = i[2:0];
        end
        for (int k = 0; k < n_random; k++) begin
            if (k % 10 == 9) begin
                // store of the latest destination
                take_bits(1, r);
                op = r[0] ? cpu_pkg::op_swi : cpu_pkg::op_swd;
            end else begin
                do begin
                    take_bits(4, r);
                end while (r > 8'd12);
                op = cpu_pkg::opcode_e'(r);
            end
            take_bits(3, hi);
            take_bits(3, r);
            rs1 = (k % 10 == 9) ? last_dest : r[2:0];
            // immediate, rs2 sits in its low bits
            take_bits(8, lo);
            if (op inside {cpu_pkg::op_lwi, cpu_pkg::op_swi}) begin
                // narrow window so loads find earlier stores
                lo[7:4] = 4'h0;
            end
            if (op inside {cpu_pkg::op_j, cpu_pkg::op_beq, cpu_pkg::op_bne}) begin
                // forward skip only, never past the final loop
                max_skip = final_idx - (n_regs + k) - 1;
                if (max_skip > 2) begin
                    max_skip = 2;
                end
                take_bits(2, r);
                hi = 8'(int'(r) % (max_skip + 1));
            end
            if (op inside {cpu_pkg::op_loadi, cpu_pkg::op_mov, cpu_pkg::op_add, cpu_pkg::op_sub,
                           cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_lwd, cpu_pkg::op_lwi}) begin
                last_dest = hi[2:0];
            end
            program_mem[n_regs + k] = encode(op, hi, rs1, lo);
        end
        // j with offset -1 spins in place
        program_mem[final_idx] = encode(cpu_pkg::op_j, 8'hff, 3'd0, 8'h00);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("*** FAILED ***");
        $fatal(1, "mismatch at model pc 0x%0h", exp_pc);
    endtask

    // architectural effect of one instruction
    task automatic retire(input logic [31:0] instr);
        cpu_pkg::opcode_e op;
        logic [2:0]       rd;
        logic [2:0]       rs1;
        logic [2:0]       rs2;
        logic [7:0]       imm;
        logic [7:0]       off;
        logic [31:0]      next_pc;
        logic             taken;
        op      = cpu_pkg::opcode_e'(instr[31:24]);
        off     = instr[23:16];
        rd      = instr[18:16];
        rs1     = instr[10:8];
        rs2     = instr[2:0];
        imm     = instr[7:0];
        next_pc = exp_pc + 32'd4;
        taken   = 1'b0;
        case (op)
            cpu_pkg::op_loadi: model_regs[rd] = imm;
            cpu_pkg::op_mov:   model_regs[rd] = model_regs[rs2];
            cpu_pkg::op_add:   model_regs[rd] = model_regs[rs1] + model_regs[rs2];
            cpu_pkg::op_sub:   model_regs[rd] = model_regs[rs1] - model_regs[rs2];
            cpu_pkg::op_and:   model_regs[rd] = model_regs[rs1] & model_regs[rs2];
            cpu_pkg::op_or:    model_regs[rd] = model_regs[rs1] | model_regs[rs2];
            cpu_pkg::op_j:     taken = 1'b1;
            cpu_pkg::op_beq:   taken = (model_regs[rs1] == model_regs[rs2]);
            cpu_pkg::op_bne:   taken = (model_regs[rs1] != model_regs[rs2]);
            cpu_pkg::op_lwd:   model_regs[rd] = model_dmem[model_regs[rs2]];
            cpu_pkg::op_lwi:   model_regs[rd] = model_dmem[imm];
            cpu_pkg::op_swd:   model_dmem[model_regs[rs2]] = model_regs[rs1];
            cpu_pkg::op_swi:   model_dmem[imm] = model_regs[rs1];
            default: begin
            end
        endcase
        // signed word offset from the next instruction
        if (taken) begin
            next_pc = next_pc + 32'($signed(off) * 4);
        end
        if (op == cpu_pkg::op_j && next_pc == exp_pc) begin
            done = 1'b1;
        end
        exp_pc = next_pc;
    endtask

    // compare outputs mid-cycle, then advance the model
    task automatic check_and_step();
        logic [31:0]      instr;
        cpu_pkg::opcode_e op;
        logic [2:0]       rs1;
        logic [2:0]       rs2;
        logic [7:0]       imm;
        logic             is_store;
        logic             is_mem;
        logic [7:0]       st_addr;
        instr    = program_mem[exp_pc[31:2]];
        op       = cpu_pkg::opcode_e'(instr[31:24]);
        rs1      = instr[10:8];
        rs2      = instr[2:0];
        imm      = instr[7:0];
        is_store = (op inside {cpu_pkg::op_swd, cpu_pkg::op_swi});
        is_mem   = is_store || (op inside {cpu_pkg::op_lwd, cpu_pkg::op_lwi});
        st_addr  = (op == cpu_pkg::op_swd) ? model_regs[rs2] : imm;
        pc_match: assert (pc == exp_pc)
            else report_mismatch("pc", pc, exp_pc);
        write_match: assert (mem_write === is_store)
            else report_mismatch("mem_write", 32'(mem_write), 32'(is_store));
        if (is_store) begin
            addr_match: assert (mem_address == st_addr)
                else report_mismatch("mem_address", 32'(mem_address), 32'(st_addr));
            data_match: assert (mem_writedata == model_regs[rs1])
                else report_mismatch("mem_writedata", 32'(mem_writedata),
                                     32'(model_regs[rs1]));
        end
        // memory ops stall mem_latency cycles, the rest take one
        cycles_here++;
        if (cycles_here == (is_mem ? mem_latency + 1 : 1)) begin
            cycles_here = 0;
            retire(instr);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            check_and_step();
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("*** FAILED ***");
            $fatal(1, "timeout: program did not reach its final loop in %0d cycles", cycle_limit);
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        exp_pc      = 32'h0;
        cycles_here = 0;
        cycle_cnt   = 0;
        done        = 1'b0;
        // model mirrors the cleared register file and memory
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 8'h00;
        end
        for (int i = 0; i < 256; i++) begin
            model_dmem[i] = 8'h00;
        end
        build_program();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        while (!done) begin
            @(posedge clk);
        end
        // pc must stay on the final loop
        repeat (3) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== files.f ====
hw/cpu_pkg.sv
hw/pc_unit.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/cpu_core.sv
hw/data_memory.sv
hw/cpu_system.sv
verif/tb_cpu_system.sv
